/* Bender.yml */
package:
  name: shader_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ray_pkg.sv
      - rtl/shader_pkg.sv
      - rtl/shade_ret_if.sv
      - rtl/ray_id_pool.sv
      - rtl/return_arbiter.sv
      - rtl/color_stage.sv
      - rtl/shader_ctrl.sv
      - rtl/shader_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/shader_checker.sv
      - testbench/tb_shader_unit.sv

/* compile.f */
+incdir+rtl
rtl/ray_pkg.sv
rtl/shader_pkg.sv
rtl/shade_ret_if.sv
rtl/ray_id_pool.sv
rtl/return_arbiter.sv
rtl/color_stage.sv
rtl/shader_ctrl.sv
rtl/shader_unit.sv
testbench/shader_checker.sv
testbench/tb_shader_unit.sv

/* rtl/color_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "shader_defs.svh"

module color_stage import shader_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      tag_we,
  input  ray_id_t   tag_addr,
  input  pixel_id_t tag_pixel,
  shade_ret_if.mon  ret,
  output logic      room,
  input  logic      pb_full,
  output logic      pb_we,
  output pb_entry_t pb_data
);

  localparam int DEPTH = `SH_OUT_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  pixel_id_t        tag_mem [`SH_NUM_RAYS];
  pixel_id_t        rd_pixel;
  logic             s1_valid;
  hit_rec_t         s1_hit;
  pb_entry_t        fifo_mem [DEPTH];
  pb_entry_t        fifo_din;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             fifo_we;
  logic             fifo_re;
  logic             fifo_full;
  logic             fifo_empty;

  function automatic color_t calc_color(hit_rec_t h);
    if (!h.hit) begin
      return `SH_MISS_COLOR;
    end
    case (h.tri_id[1:0])
      2'd0:    return `SH_TRI0_COLOR;
      2'd1:    return `SH_TRI1_COLOR;
      2'd2:    return `SH_TRI2_COLOR;
      default: return `SH_TRI3_COLOR;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // tag ram, written at launch and read on return
  always_ff @(posedge clk) begin
    if (tag_we) begin
      tag_mem[tag_addr] <= tag_pixel;
    end
    rd_pixel <= tag_mem[ret.ray_id];
  end

  // hit record follows the ram read by one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= ret.valid && !ret.stall;
    end
  end

  always_ff @(posedge clk) begin
    s1_hit <= ret.hit;
  end

  // ----------------------------------------------------------------------
  // output fifo towards the pixel buffer
  assign fifo_din.color = calc_color(s1_hit);
  assign fifo_din.pixel = rd_pixel;
  assign fifo_we        = s1_valid;
  assign fifo_re        = !fifo_empty && !pb_full;
  assign fifo_empty     = (count == '0);
  assign fifo_full      = (count == CNT_W'(DEPTH));

  always_ff @(posedge clk) begin
    if (fifo_we) begin
      fifo_mem[wr_ptr] <= fifo_din;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (fifo_we) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (fifo_re) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(fifo_we) - CNT_W'(fifo_re);
    end
  end

  // keep a slot for whatever sits in the read stage
  assign room    = (CNT_W'(DEPTH) - count) > CNT_W'(s1_valid);
  assign pb_we   = fifo_re;
  assign pb_data = fifo_mem[rd_ptr];

  // room check one cycle earlier must prevent overflow
  a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
    fifo_we |-> !fifo_full);

endmodule

`default_nettype wire

/* rtl/ray_id_pool.sv */
`timescale 1ns/100ps
`default_nettype none

`include "shader_defs.svh"

module ray_id_pool import shader_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    push,
  input  ray_id_t push_id,
  input  logic    pop,
  output ray_id_t head_id,
  output logic    empty
);

  localparam int DEPTH = `SH_NUM_RAYS;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  ray_id_t          mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_id;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // fall-through head, oldest free id
  assign head_id = mem[rd_ptr];
  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));

  // every id exists once, so the pool can never overflow
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty);

endmodule

`default_nettype wire

/* rtl/ray_pkg.sv */
`default_nettype none

`include "shader_defs.svh"

package ray_pkg;

  // one fixed point coordinate
  typedef logic [`SH_COORD_W-1:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  // ray as handed from the generator to intersection
  typedef struct packed {
    vec3_t origin;
    vec3_t dir;
  } ray_vec_t;

endpackage

`default_nettype wire

/* rtl/return_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module return_arbiter import shader_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  input  logic    [3:0] src_valid,
  input  ray_id_t [3:0] src_ray_id,
  input  tri_id_t       pcalc_tri,
  output logic    [3:0] src_stall,
  shade_ret_if.mst      ret
);

  localparam int NUM_SRC = 4;

  ret_src_t   rr_ptr;
  ret_src_t   win_src;
  logic       any_valid;
  logic [3:0] grant;

  // ----------------------------------------------------------------------
  // round robin search starting at the pointer
  always_comb begin
    any_valid = 1'b0;
    win_src   = rr_ptr;
    for (int k = 0; k < NUM_SRC; k++) begin
      if (!any_valid && src_valid[2'(rr_ptr + k)]) begin
        any_valid = 1'b1;
        win_src   = ret_src_t'(2'(rr_ptr + k));
      end
    end
  end

  assign grant = any_valid ? (4'b0001 << win_src) : 4'b0000;

  // losers always wait, the winner waits on downstream
  assign src_stall = ~grant | {NUM_SRC{ret.stall}};

  assign ret.valid  = any_valid;
  assign ret.ray_id = src_ray_id[win_src];

  // hit rule per source kind
  always_comb begin
    case (win_src)
      src_pcalc: ret.hit = '{hit: 1'b1, tri_id: pcalc_tri};
      src_int:   ret.hit = '{hit: 1'b1, tri_id: '0};
      default:   ret.hit = '{hit: 1'b0, tri_id: '0};
    endcase
  end

  // pointer moves just past the winner
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rr_ptr <= src_pcalc;
    end else if (ret.valid && !ret.stall) begin
      rr_ptr <= ret_src_t'(win_src + 2'd1);
    end
  end

  // one grant at a time, and the last winner waits behind any other valid source
  a_one_xfer: assert property (@(posedge clk) disable iff (!arst_n)
    ($past(ret.valid && !ret.stall) &&
     ((src_valid & ~(4'b0001 << $past(win_src))) != 4'b0000))
    |-> ($onehot(grant) && !grant[$past(win_src)]));

endmodule

`default_nettype wire

/* rtl/shade_ret_if.sv */
`timescale 1ns/100ps
`default_nettype none

// one completed ray on its way back to the shader
interface shade_ret_if import shader_pkg::*; ();

  logic     valid;
  logic     stall;
  ray_id_t  ray_id;
  hit_rec_t hit;

  // arbiter side
  modport mst (output valid, output ray_id, output hit, input stall);

  // control, decides on stall
  modport slv (input valid, input ray_id, input hit, output stall);

  // color stage only watches
  modport mon (input valid, input stall, input ray_id, input hit);

endinterface

`default_nettype wire

/* rtl/shader_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "shader_defs.svh"

module shader_ctrl import shader_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     pool_empty,
  input  ray_id_t  pool_head,
  output logic     pool_push,
  output ray_id_t  pool_push_id,
  output logic     pool_pop,
  input  logic     prg_valid,
  output logic     prg_stall,
  output logic     sint_valid,
  input  logic     sint_stall,
  input  logic     room,
  shade_ret_if.slv ret
);

  localparam ray_id_t LAST_ID = ray_id_t'(`SH_NUM_RAYS - 1);

  init_state_t state;
  ray_id_t     fill_cnt;
  logic        filling;
  logic        ret_xfer;

  assign filling = (state == init_fill);

  // ----------------------------------------------------------------------
  // init, load every id once into the pool
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= init_fill;
      fill_cnt <= '0;
    end else if (filling) begin
      fill_cnt <= fill_cnt + 1'b1;
      if (fill_cnt == LAST_ID) begin
        state <= init_run;
      end
    end
  end

  // launch side
  assign prg_stall  = sint_stall || pool_empty || filling;
  assign sint_valid = prg_valid && !pool_empty && !filling;
  assign pool_pop   = prg_valid && !prg_stall;

  // return side, retire id back to the pool
  assign ret.stall    = filling || !room;
  assign ret_xfer     = ret.valid && !ret.stall;
  assign pool_push    = filling || ret_xfer;
  assign pool_push_id = filling ? fill_cnt : ret.ray_id;

  // an id coming back is in flight, so it cannot be the free head
  a_head_not_inflight: assert property (@(posedge clk) disable iff (!arst_n)
    (pool_pop && ret_xfer) |-> (pool_head != ret.ray_id));

endmodule

`default_nettype wire

/* rtl/shader_defs.svh */
`ifndef SHADER_DEFS_SVH
`define SHADER_DEFS_SVH

// ray identifier space
`define SH_NUM_RAYS   16
`define SH_RAY_ID_W   4

// payload widths
`define SH_PIXEL_W    12
`define SH_TRI_W      8
`define SH_COORD_W    16
`define SH_COLOR_W    24

// depth of the pixel buffer side fifo
`define SH_OUT_DEPTH  4

// color table, 8 bits per channel as rgb
`define SH_MISS_COLOR 24'h20_20_40
`define SH_TRI0_COLOR 24'hff_00_00
`define SH_TRI1_COLOR 24'h00_ff_00
`define SH_TRI2_COLOR 24'h00_00_ff
`define SH_TRI3_COLOR 24'hff_ff_00

`endif

/* rtl/shader_pkg.sv */
`default_nettype none

`include "shader_defs.svh"

package shader_pkg;

  typedef logic [`SH_RAY_ID_W-1:0] ray_id_t;
  typedef logic [`SH_PIXEL_W-1:0]  pixel_id_t;
  typedef logic [`SH_TRI_W-1:0]    tri_id_t;
  typedef logic [`SH_COLOR_W-1:0]  color_t;

  // one pixel buffer write
  typedef struct packed {
    color_t    color;
    pixel_id_t pixel;
  } pb_entry_t;

  // hit record carried with a completed ray
  typedef struct packed {
    logic    hit;
    tri_id_t tri_id;
  } hit_rec_t;

  // return sources, value is also the arbiter input index
  typedef enum logic [1:0] {
    src_pcalc = 2'd0,
    src_int   = 2'd1,
    src_sint  = 2'd2,
    src_ss    = 2'd3
  } ret_src_t;

  typedef enum logic {
    init_fill = 1'b0,
    init_run  = 1'b1
  } init_state_t;

endpackage

`default_nettype wire

/* rtl/shader_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module shader_unit import ray_pkg::*, shader_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  // primary ray generator
  input  logic      prg_valid,
  input  pixel_id_t prg_pixel,
  input  ray_vec_t  prg_ray,
  output logic      prg_stall,
  // launch towards intersection
  output logic      sint_valid,
  output ray_id_t   sint_ray_id,
  output ray_vec_t  sint_ray,
  input  logic      sint_stall,
  // return sources
  input  logic      pcalc_valid,
  input  ray_id_t   pcalc_ray_id,
  input  tri_id_t   pcalc_tri,
  output logic      pcalc_stall,
  input  logic      int_valid,
  input  ray_id_t   int_ray_id,
  output logic      int_stall,
  input  logic      sint_ret_valid,
  input  ray_id_t   sint_ret_ray_id,
  output logic      sint_ret_stall,
  input  logic      ss_valid,
  input  ray_id_t   ss_ray_id,
  output logic      ss_stall,
  // pixel buffer
  output logic      pb_we,
  input  logic      pb_full,
  output pb_entry_t pb_data
);

  logic       pool_push;
  ray_id_t    pool_push_id;
  logic       pool_pop;
  ray_id_t    pool_head;
  logic       pool_empty;
  logic       room;
  logic [3:0] arb_stall;

  shade_ret_if ret_if ();

  ray_id_pool ray_id_pool_i (
    .clk,
    .arst_n,
    .push    (pool_push),
    .push_id (pool_push_id),
    .pop     (pool_pop),
    .head_id (pool_head),
    .empty   (pool_empty)
  );

  // index order follows ret_src_t
  return_arbiter return_arbiter_i (
    .clk,
    .arst_n,
    .src_valid  ({ss_valid, sint_ret_valid, int_valid, pcalc_valid}),
    .src_ray_id ({ss_ray_id, sint_ret_ray_id, int_ray_id, pcalc_ray_id}),
    .pcalc_tri,
    .src_stall  (arb_stall),
    .ret        (ret_if.mst)
  );

  color_stage color_stage_i (
    .clk,
    .arst_n,
    .tag_we    (pool_pop),
    .tag_addr  (pool_head),
    .tag_pixel (prg_pixel),
    .ret       (ret_if.mon),
    .room,
    .pb_full,
    .pb_we,
    .pb_data
  );

  shader_ctrl shader_ctrl_i (
    .clk,
    .arst_n,
    .pool_empty,
    .pool_head,
    .pool_push,
    .pool_push_id,
    .pool_pop,
    .prg_valid,
    .prg_stall,
    .sint_valid,
    .sint_stall,
    .room,
    .ret          (ret_if.slv)
  );

  assign pcalc_stall    = arb_stall[src_pcalc];
  assign int_stall      = arb_stall[src_int];
  assign sint_ret_stall = arb_stall[src_sint];
  assign ss_stall       = arb_stall[src_ss];

  assign sint_ray_id = pool_head;
  assign sint_ray    = prg_ray;

endmodule

`default_nettype wire

/* testbench/shader_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "shader_defs.svh"

module shader_checker import ray_pkg::*, shader_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          prg_valid,
  input  pixel_id_t     prg_pixel,
  input  ray_vec_t      prg_ray,
  input  logic          prg_stall,
  input  logic          sint_valid,
  input  ray_id_t       sint_ray_id,
  input  ray_vec_t      sint_ray,
  input  logic          sint_stall,
  input  logic    [3:0] src_valid,
  input  ray_id_t [3:0] src_ray_id,
  input  tri_id_t       pcalc_tri,
  input  logic    [3:0] src_stall,
  input  logic          pb_we,
  input  logic          pb_full,
  input  pb_entry_t     pb_data,
  output int            errors,
  output int            pending
);

  localparam int NUM_RAYS = `SH_NUM_RAYS;
  localparam int DEPTH    = `SH_OUT_DEPTH;

  ray_id_t   free_q [$];
  pb_entry_t exp_q [$];
  int        fair_q [$];
  pixel_id_t pixel_map [NUM_RAYS];
  logic      in_flight [NUM_RAYS];
  int        init_cnt;
  int        rr_ptr;
  int        fifo_cnt;
  logic      pend;
  logic      ret_xfer;

  initial begin
    errors  = 0;
    pending = 0;
  end

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // color from the source kind and the two low triangle bits
  function automatic color_t expected_color(input int src, input tri_id_t tri_in);
    tri_id_t sel;
    if (src == src_sint || src == src_ss) begin
      return `SH_MISS_COLOR;
    end
    sel = (src == src_pcalc) ? tri_in : '0;
    case (sel[1:0])
      2'd0:    return `SH_TRI0_COLOR;
      2'd1:    return `SH_TRI1_COLOR;
      2'd2:    return `SH_TRI2_COLOR;
      default: return `SH_TRI3_COLOR;
    endcase
  endfunction

  task automatic reset_model();
    free_q.delete();
    exp_q.delete();
    fair_q.delete();
    for (int i = 0; i < NUM_RAYS; i++) begin
      free_q.push_back(ray_id_t'(i));
      in_flight[i] = 1'b0;
    end
    init_cnt = 0;
    rr_ptr   = 0;
    fifo_cnt = 0;
    pend     = 1'b0;
    ret_xfer = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // per cycle checks, sampled mid-cycle where everything is settled
  task automatic check_init();
    if (prg_stall !== 1'b1 || sint_valid !== 1'b0 || pb_we !== 1'b0 ||
        src_stall !== 4'hf) begin
      report_mismatch($sformatf("init: prg_stall %b sint_valid %b pb_we %b stalls %b",
                                prg_stall, sint_valid, pb_we, src_stall));
    end
  endtask

  task automatic check_launch();
    logic    exp_stall;
    logic    exp_valid;
    ray_id_t id;
    exp_stall = sint_stall || (free_q.size() == 0);
    exp_valid = prg_valid && (free_q.size() != 0);
    if (prg_stall !== exp_stall) begin
      report_mismatch($sformatf("prg_stall %b, expected %b", prg_stall, exp_stall));
    end
    if (sint_valid !== exp_valid) begin
      report_mismatch($sformatf("sint_valid %b, expected %b", sint_valid, exp_valid));
    end
    if (prg_valid && !exp_stall) begin
      id = free_q.pop_front();
      if (sint_ray_id !== id) begin
        report_mismatch($sformatf("launch id %0d, expected %0d", sint_ray_id, id));
      end
      if (sint_ray !== prg_ray) begin
        report_mismatch("sint_ray differs from prg_ray");
      end
      pixel_map[id] = prg_pixel;
      in_flight[id] = 1'b1;
    end
  endtask

  task automatic check_return();
    logic [3:0] exp_stall;
    logic [3:0] seen;
    logic       room;
    logic       found;
    int         win;
    int         idx;
    ray_id_t    id;
    found = 1'b0;
    win   = 0;
    room  = (DEPTH - fifo_cnt) > int'(pend);
    for (int k = 0; k < 4; k++) begin
      idx = (rr_ptr + k) % 4;
      if (!found && src_valid[idx]) begin
        found = 1'b1;
        win   = idx;
      end
    end
    exp_stall = 4'hf;
    if (found && room) begin
      exp_stall[win] = 1'b0;
    end
    if (src_stall !== exp_stall) begin
      report_mismatch($sformatf("return stalls %b, expected %b", src_stall, exp_stall));
    end
    ret_xfer = found && room;
    if (ret_xfer) begin
      id = src_ray_id[win];
      if (!in_flight[id]) begin
        report_failure($sformatf("identifier %0d came back while not in flight", id));
      end
      in_flight[id] = 1'b0;
      free_q.push_back(id);
      exp_q.push_back('{color: expected_color(win, pcalc_tri), pixel: pixel_map[id]});
      rr_ptr = (win + 1) % 4;
      // fairness window over grants with every source waiting
      if (src_valid == 4'hf) begin
        fair_q.push_back(win);
        if (fair_q.size() > 4) begin
          void'(fair_q.pop_front());
        end
        if (fair_q.size() == 4) begin
          seen = '0;
          foreach (fair_q[i]) begin
            seen[fair_q[i]] = 1'b1;
          end
          if (seen != 4'hf) begin
            report_failure("a return source was skipped within four grants");
          end
        end
      end else begin
        fair_q.delete();
      end
    end
  endtask

  task automatic check_output();
    logic      exp_we;
    pb_entry_t exp;
    exp_we = (fifo_cnt > 0) && !pb_full;
    if (pb_we !== exp_we) begin
      report_mismatch($sformatf("pb_we %b, expected %b with pb_full %b",
                                pb_we, exp_we, pb_full));
    end
    if (pb_we === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_failure("pixel buffer written with no return outstanding");
      end else begin
        exp = exp_q.pop_front();
        if (pb_data !== exp) begin
          report_mismatch($sformatf("pb_data color %h pixel %h, expected color %h pixel %h",
                                    pb_data.color, pb_data.pixel, exp.color, exp.pixel));
        end
      end
    end
    fifo_cnt = fifo_cnt + int'(pend) - int'(exp_we);
    pend     = ret_xfer;
  endtask

  always @(negedge clk) begin
    if (!arst_n) begin
      reset_model();
    end else if (init_cnt < NUM_RAYS) begin
      check_init();
      init_cnt++;
    end else begin
      check_launch();
      check_return();
      check_output();
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

/* testbench/tb_shader_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "shader_defs.svh"

module tb_shader_unit import ray_pkg::*, shader_pkg::*; ();

  localparam int N_INIT  = `SH_NUM_RAYS;
  localparam int N_EMPTY = 1;
  localparam int N_COLOR = 64;
  localparam int N_REUSE = 48;
  localparam int N_BP    = 64;
  localparam int N_FILL  = `SH_NUM_RAYS;
  localparam int N_FAIR  = 64;
  // every launch is followed by one return
  localparam int TOTAL_OPS = 2 * (N_INIT + N_EMPTY + N_COLOR + N_REUSE + N_BP +
                                  N_FILL + N_FAIR);
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 20 + `SH_NUM_RAYS + 3;

  logic          clk;
  logic          arst_n;
  logic          prg_valid;
  pixel_id_t     prg_pixel;
  ray_vec_t      prg_ray;
  logic          prg_stall;
  logic          sint_valid;
  ray_id_t       sint_ray_id;
  ray_vec_t      sint_ray;
  logic          sint_stall;
  logic    [3:0] ret_v;
  ray_id_t [3:0] ret_id;
  tri_id_t       pcalc_tri;
  wire     [3:0] ret_stall;
  logic          pb_we;
  logic          pb_full;
  pb_entry_t     pb_data;
  int            errors;
  int            pending;

  logic [15:0] lfsr;
  ray_id_t     inflight [$];
  int          total_launched;
  int          total_returned;
  int          tests_run;
  int          tests_failed;
  int          err_mark;

  always #20 clk = ~clk;

  shader_unit shader_unit_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .prg_valid       (prg_valid),
    .prg_pixel       (prg_pixel),
    .prg_ray         (prg_ray),
    .prg_stall       (prg_stall),
    .sint_valid      (sint_valid),
    .sint_ray_id     (sint_ray_id),
    .sint_ray        (sint_ray),
    .sint_stall      (sint_stall),
    .pcalc_valid     (ret_v[0]),
    .pcalc_ray_id    (ret_id[0]),
    .pcalc_tri       (pcalc_tri),
    .pcalc_stall     (ret_stall[0]),
    .int_valid       (ret_v[1]),
    .int_ray_id      (ret_id[1]),
    .int_stall       (ret_stall[1]),
    .sint_ret_valid  (ret_v[2]),
    .sint_ret_ray_id (ret_id[2]),
    .sint_ret_stall  (ret_stall[2]),
    .ss_valid        (ret_v[3]),
    .ss_ray_id       (ret_id[3]),
    .ss_stall        (ret_stall[3]),
    .pb_we           (pb_we),
    .pb_full         (pb_full),
    .pb_data         (pb_data)
  );

  shader_checker checks_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .prg_valid   (prg_valid),
    .prg_pixel   (prg_pixel),
    .prg_ray     (prg_ray),
    .prg_stall   (prg_stall),
    .sint_valid  (sint_valid),
    .sint_ray_id (sint_ray_id),
    .sint_ray    (sint_ray),
    .sint_stall  (sint_stall),
    .src_valid   (ret_v),
    .src_ray_id  (ret_id),
    .pcalc_tri   (pcalc_tri),
    .src_stall   (ret_stall),
    .pb_we       (pb_we),
    .pb_full     (pb_full),
    .pb_data     (pb_data),
    .errors      (errors),
    .pending     (pending)
  );

  // ------------------------------------------------------------------
  // galois lfsr, one step per bit
  function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 16'hb400;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  // true with probability p/8
  function automatic logic chance(input int p);
    return rand_bits(3) < p;
  endfunction

  // ------------------------------------------------------------------
  // random launches and returns until n_launch more rays have launched
  task automatic run_traffic(input int n_launch, input int p_launch, input int p_ret,
                             input int p_sstall, input int p_full, input logic drain);
    int         start;
    int         idx;
    logic       busy;
    logic [3:0] v_next;
    start = total_launched;
    busy  = 1'b1;
    while (busy) begin
      @(posedge clk);
      if (prg_valid && !prg_stall) begin
        total_launched++;
        inflight.push_back(sint_ray_id);
      end
      for (int k = 0; k < 4; k++) begin
        v_next[k] = ret_v[k] && ret_stall[k];
        if (ret_v[k] && !ret_stall[k]) begin
          total_returned++;
        end
      end
      if (total_launched - start >= n_launch &&
          (!drain || (total_returned == total_launched && pending == 0))) begin
        busy = 1'b0;
      end
      // only rays in flight are handed back
      for (int k = 0; k < 4; k++) begin
        if (busy && !v_next[k] && inflight.size() > 0 && chance(p_ret)) begin
          idx = int'(rand_bits(4)) % inflight.size();
          ret_id[k] <= inflight[idx];
          inflight.delete(idx);
          v_next[k] = 1'b1;
          if (k == 0) begin
            pcalc_tri <= tri_id_t'(rand_bits(`SH_TRI_W));
          end
        end
      end
      ret_v      <= v_next;
      prg_valid  <= busy && (total_launched - start < n_launch) && chance(p_launch);
      prg_pixel  <= pixel_id_t'(rand_bits(`SH_PIXEL_W));
      prg_ray    <= {rand_bits(32), rand_bits(32), rand_bits(32)};
      sint_stall <= busy && chance(p_sstall);
      pb_full    <= busy && chance(p_full);
    end
  endtask

  task automatic finish_test(input string name);
    int n;
    n = errors - err_mark;
    tests_run++;
    if (n == 0) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s %0d errors", name, n);
    end
    err_mark = errors;
  endtask

  initial begin
    clk            = 1'b0;
    arst_n         = 1'b0;
    prg_valid      = 1'b0;
    prg_pixel      = '0;
    prg_ray        = '0;
    sint_stall     = 1'b0;
    ret_v          = '0;
    ret_id         = '0;
    pcalc_tri      = '0;
    pb_full        = 1'b0;
    lfsr           = 16'd21702;
    total_launched = 0;
    total_returned = 0;
    tests_run      = 0;
    tests_failed   = 0;
    err_mark       = 0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    run_traffic(N_INIT, 8, 0, 0, 0, 1'b0);
    finish_test("init_order");

    // pool is empty now, launches must wait for a return
    repeat (10) begin
      @(posedge clk);
      prg_valid <= 1'b1;
    end
    run_traffic(N_EMPTY, 8, 2, 0, 0, 1'b1);
    finish_test("empty_pool");

    run_traffic(N_COLOR, 5, 4, 2, 0, 1'b1);
    finish_test("colors");
    run_traffic(N_REUSE, 8, 6, 0, 0, 1'b1);
    finish_test("reuse");
    run_traffic(N_BP, 6, 6, 1, 5, 1'b1);
    finish_test("pb_backpress");

    // every id in flight first, so all four sources can stay valid
    run_traffic(N_FILL, 8, 0, 0, 0, 1'b0);
    run_traffic(N_FAIR, 8, 8, 0, 0, 1'b1);
    finish_test("fairness");

    repeat (4) @(posedge clk);
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
